// ==== logic/video_timing_pkg.sv ====
package video_timing_pkg;

	////////////////////////////////////////
	// raster position types
	////////////////////////////////////////

	// dot number within a line
	// 7 bits covers up to 128 dots per line
	typedef logic [6:0] hpos_t;

	// line number within a frame
	// 6 bits covers up to 64 lines per frame
	typedef logic [5:0] vpos_t;

	////////////////////////////////////////
	// default raster geometry
	////////////////////////////////////////

	// horizontal timing in dot clocks
	localparam int H_ACTIVE     = 64;
	localparam int H_TOTAL      = 80;
	localparam int H_SYNC_START = 68;
	localparam int H_SYNC_LEN   = 4;

	// vertical timing in whole lines
	localparam int V_ACTIVE     = 32;
	localparam int V_TOTAL      = 40;
	localparam int V_SYNC_START = 34;
	localparam int V_SYNC_LEN   = 2;

	////////////////////////////////////////
	// pipeline latency
	////////////////////////////////////////

	// clocks from a registered beam position to its dot
	// three in each layer and two in the mixer
	localparam int PIPE_DEPTH = 5;

endpackage

// ==== logic/tile_pkg.sv ====
package tile_pkg;

	////////////////////////////////////////
	// cpu bus
	////////////////////////////////////////

	typedef logic [12:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	////////////////////////////////////////
	// tile layer data
	////////////////////////////////////////

	// offset into the 128 by 128 dot map, also used for map coordinates
	typedef logic [6:0]  scroll_t;
	// 16 by 16 tile map, row in the high nibble
	typedef logic [7:0]  map_index_t;
	typedef logic [4:0]  tile_code_t;
	typedef logic [2:0]  bank_t;
	// zero is the transparent pen
	typedef logic [2:0]  pixel_t;
	// tile code, fine y, fine x
	typedef logic [10:0] pattern_addr_t;
	typedef logic [2:0]  priority_t;
	// layer id, bank, pixel
	typedef logic [6:0]  color_index_t;
	typedef logic [7:0]  dot_t;

	localparam pixel_t PIXEL_CLEAR = '0;

	////////////////////////////////////////
	// cpu address map
	////////////////////////////////////////

	// tile maps, one 256 byte window per layer
	localparam cpu_addr_t MAP_BASE       = 13'h0000;
	localparam cpu_addr_t MAP_STRIDE     = 13'h0100;

	// pattern memories, one 2k window per layer
	localparam cpu_addr_t PATTERN_BASE   = 13'h0800;
	localparam cpu_addr_t PATTERN_STRIDE = 13'h0800;

	// palette, 128 dot values
	localparam cpu_addr_t PALETTE_BASE   = 13'h1800;
	localparam int        PALETTE_SIZE   = 128;

	// layer registers, four addresses per layer
	localparam cpu_addr_t REG_BASE       = 13'h1900;
	localparam cpu_addr_t REG_STRIDE     = 13'h0004;
	localparam cpu_addr_t REG_SCROLL_X   = 13'h0000;
	localparam cpu_addr_t REG_SCROLL_Y   = 13'h0001;
	localparam cpu_addr_t REG_PRIORITY   = 13'h0002;

	// background color index latch
	localparam cpu_addr_t BACKGROUND_REG = 13'h1908;

endpackage

// ==== logic/beam_if.sv ====
`timescale 1ns/1ps

interface beam_if
	import video_timing_pkg::*;
	();

	// raster position of the current dot
	hpos_t hpos;
	vpos_t vpos;

	// high inside the visible window
	logic active;

	// sync, low inside the sync windows
	logic hsync_n;
	logic vsync_n;

	// beam counter side
	modport source (
		output hpos, vpos, active, hsync_n, vsync_n
	);

	// layers and mixer
	modport sink (
		input hpos, vpos, active, hsync_n, vsync_n
	);

endinterface

// ==== logic/beam_counter.sv ====
`timescale 1ns/1ps

module beam_counter
	import video_timing_pkg::*;
	#(
		parameter int H_ACTIVE     = video_timing_pkg::H_ACTIVE,
		parameter int H_TOTAL      = video_timing_pkg::H_TOTAL,
		parameter int H_SYNC_START = video_timing_pkg::H_SYNC_START,
		parameter int H_SYNC_LEN   = video_timing_pkg::H_SYNC_LEN,
		parameter int V_ACTIVE     = video_timing_pkg::V_ACTIVE,
		parameter int V_TOTAL      = video_timing_pkg::V_TOTAL,
		parameter int V_SYNC_START = video_timing_pkg::V_SYNC_START,
		parameter int V_SYNC_LEN   = video_timing_pkg::V_SYNC_LEN
	)
	(
		input logic clk_6m,
		input logic arst_n,
		beam_if.source beam
	);

	// position the beam moves to on the next clock
	hpos_t h_next;
	vpos_t v_next;
	logic  line_end;

	always_comb begin
		line_end = (beam.hpos == hpos_t'(H_TOTAL - 1));
		h_next   = line_end ? '0 : beam.hpos + 1'b1;
		v_next   = beam.vpos;
		// vertical advances once per line wrap
		if (line_end) begin
			v_next = (beam.vpos == vpos_t'(V_TOTAL - 1)) ? '0 : beam.vpos + 1'b1;
		end
	end

	////////////////////////////////////////
	// registered beam outputs
	////////////////////////////////////////

	// flags are decoded from the next position
	// so they line up with hpos and vpos
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			// park on the last dot of the frame
			// the first clock then starts line zero of frame zero
			beam.hpos    <= hpos_t'(H_TOTAL - 1);
			beam.vpos    <= vpos_t'(V_TOTAL - 1);
			beam.active  <= 1'b0;
			beam.hsync_n <= 1'b1;
			beam.vsync_n <= 1'b1;
		end else begin
			beam.hpos    <= h_next;
			beam.vpos    <= v_next;
			beam.active  <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
			// sync low inside its window
			beam.hsync_n <= !((h_next >= H_SYNC_START) &&
				(h_next < H_SYNC_START + H_SYNC_LEN));
			beam.vsync_n <= !((v_next >= V_SYNC_START) &&
				(v_next < V_SYNC_START + V_SYNC_LEN));
		end
	end

endmodule

// ==== logic/tile_layer.sv ====
`timescale 1ns/1ps

module tile_layer
	import tile_pkg::*;
	#(
		parameter int LAYER_ID = 0
	)
	(
		input  logic      clk_6m,
		input  logic      arst_n,
		beam_if.sink      beam,
		input  cpu_addr_t cpu_addr,
		input  cpu_data_t cpu_data,
		input  logic      cpu_we,
		output pixel_t    layer_pixel,
		output bank_t     layer_bank,
		output priority_t layer_priority
	);

	// address windows of this layer
	localparam cpu_addr_t MAP_LO     = cpu_addr_t'(MAP_BASE + LAYER_ID * MAP_STRIDE);
	localparam cpu_addr_t PATTERN_LO = cpu_addr_t'(PATTERN_BASE + LAYER_ID * PATTERN_STRIDE);
	localparam cpu_addr_t REG_LO     = cpu_addr_t'(REG_BASE + LAYER_ID * REG_STRIDE);

	// scroll and priority registers
	scroll_t   scroll_x;
	scroll_t   scroll_y;
	priority_t prio;

	// tile map entries hold bank in [7:5] and code in [4:0]
	cpu_data_t tile_map [2**$bits(map_index_t)];
	// only the pixel bits of each pattern byte are kept
	pixel_t    pattern_mem [2**$bits(pattern_addr_t)];

	logic map_we;
	logic pattern_we;

	// scrolled map position of the current beam dot
	scroll_t    map_x;
	scroll_t    map_y;
	map_index_t map_index;

	// stage 1
	cpu_data_t  map_entry;
	logic [2:0] fine_x;
	logic [2:0] fine_y;

	// stage 2
	tile_code_t    tile_code;
	pattern_addr_t pattern_addr;
	pixel_t        pattern_pixel;
	bank_t         entry_bank;

	////////////////////////////////////////
	// cpu writes
	////////////////////////////////////////

	assign map_we     = cpu_we && (cpu_addr >= MAP_LO) && (cpu_addr < MAP_LO + MAP_STRIDE);
	assign pattern_we = cpu_we && (cpu_addr >= PATTERN_LO) &&
		(cpu_addr < PATTERN_LO + PATTERN_STRIDE);

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			scroll_x <= '0;
			scroll_y <= '0;
			prio     <= '0;
		end else if (cpu_we) begin
			// scroll x, scroll y, then priority
			if (cpu_addr == REG_LO + REG_SCROLL_X) scroll_x <= cpu_data[6:0];
			if (cpu_addr == REG_LO + REG_SCROLL_Y) scroll_y <= cpu_data[6:0];
			if (cpu_addr == REG_LO + REG_PRIORITY) prio     <= cpu_data[2:0];
		end
	end

	always_ff @(posedge clk_6m) begin
		if (map_we) begin
			tile_map[map_index_t'(cpu_addr - MAP_LO)] <= cpu_data;
		end
		if (pattern_we) begin
			pattern_mem[pattern_addr_t'(cpu_addr - PATTERN_LO)] <= cpu_data[2:0];
		end
	end

	////////////////////////////////////////
	// lookup pipeline
	////////////////////////////////////////

	// both sums wrap at 128
	always_comb begin
		map_x     = scroll_t'(beam.hpos) + scroll_x;
		map_y     = scroll_t'(beam.vpos) + scroll_y;
		// eight dot tiles, tile row above tile column
		map_index = {map_y[6:3], map_x[6:3]};
	end

	// stage 1 fetches the map entry
	always_ff @(posedge clk_6m) begin
		map_entry <= tile_map[map_index];
		fine_x    <= map_x[2:0];
		fine_y    <= map_y[2:0];
	end

	// 64 pixels per tile, row major
	assign tile_code    = map_entry[4:0];
	assign pattern_addr = {tile_code, fine_y, fine_x};

	// stage 2 fetches the pattern pixel
	always_ff @(posedge clk_6m) begin
		pattern_pixel <= pattern_mem[pattern_addr];
		entry_bank    <= map_entry[7:5];
	end

	// stage 3 presents the layer to the mixer
	always_ff @(posedge clk_6m) begin
		layer_pixel    <= pattern_pixel;
		layer_bank     <= entry_bank;
		layer_priority <= prio;
	end

endmodule

// ==== logic/layer_mixer.sv ====
`timescale 1ns/1ps

module layer_mixer
	import video_timing_pkg::*;
	import tile_pkg::*;
	(
		input  logic      clk_6m,
		input  logic      arst_n,
		beam_if.sink      beam,
		input  cpu_addr_t cpu_addr,
		input  cpu_data_t cpu_data,
		input  logic      cpu_we,
		input  pixel_t    a_pixel,
		input  bank_t     a_bank,
		input  priority_t a_priority,
		input  pixel_t    b_pixel,
		input  bank_t     b_bank,
		input  priority_t b_priority,
		output dot_t      dot,
		output logic      blank_n,
		output logic      hsync_n,
		output logic      vsync_n
	);

	// active, hsync_n, vsync_n packed per stage
	localparam logic [2:0] CTRL_IDLE = 3'b011;

	// background color index latch
	color_index_t background;

	// palette
	dot_t palette [PALETTE_SIZE];
	logic palette_we;

	logic a_opaque;
	logic b_opaque;
	color_index_t mix_index;
	color_index_t mix_index_q;

	// sync and blanking delay line
	logic [PIPE_DEPTH-1:0][2:0] ctrl_line;

	////////////////////////////////////////
	// cpu writes
	////////////////////////////////////////

	assign palette_we = cpu_we && (cpu_addr >= PALETTE_BASE) &&
		(cpu_addr < PALETTE_BASE + PALETTE_SIZE);

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			background <= '0;
		end else if (cpu_we && (cpu_addr == BACKGROUND_REG)) begin
			background <= cpu_data[6:0];
		end
	end

	always_ff @(posedge clk_6m) begin
		if (palette_we) begin
			palette[color_index_t'(cpu_addr - PALETTE_BASE)] <= cpu_data;
		end
	end

	////////////////////////////////////////
	// priority selection
	////////////////////////////////////////

	assign a_opaque = (a_pixel != PIXEL_CLEAR);
	assign b_opaque = (b_pixel != PIXEL_CLEAR);

	// ties go to layer a
	always_comb begin
		if (b_opaque && (!a_opaque || (b_priority > a_priority))) begin
			mix_index = {1'b1, b_bank, b_pixel};
		end else if (a_opaque) begin
			mix_index = {1'b0, a_bank, a_pixel};
		end else begin
			mix_index = background;
		end
	end

	// stage 4 holds the winning index
	always_ff @(posedge clk_6m) begin
		mix_index_q <= mix_index;
	end

	// stage 5 looks up the palette
	// the line tap one short of the end belongs to the index in mix_index_q
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			dot <= '0;
		end else begin
			dot <= ctrl_line[PIPE_DEPTH-2][2] ? palette[mix_index_q] : '0;
		end
	end

	////////////////////////////////////////
	// sync alignment
	////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_line <= {PIPE_DEPTH{CTRL_IDLE}};
		end else begin
			ctrl_line <= {ctrl_line[PIPE_DEPTH-2:0], {beam.active, beam.hsync_n, beam.vsync_n}};
		end
	end

	// last stage lines up with dot
	assign blank_n = ctrl_line[PIPE_DEPTH-1][2];
	assign hsync_n = ctrl_line[PIPE_DEPTH-1][1];
	assign vsync_n = ctrl_line[PIPE_DEPTH-1][0];

endmodule

// ==== logic/tilegen_top.sv ====
`timescale 1ns/1ps

module tilegen_top
	import video_timing_pkg::*;
	import tile_pkg::*;
	#(
		parameter int H_ACTIVE     = video_timing_pkg::H_ACTIVE,
		parameter int H_TOTAL      = video_timing_pkg::H_TOTAL,
		parameter int H_SYNC_START = video_timing_pkg::H_SYNC_START,
		parameter int H_SYNC_LEN   = video_timing_pkg::H_SYNC_LEN,
		parameter int V_ACTIVE     = video_timing_pkg::V_ACTIVE,
		parameter int V_TOTAL      = video_timing_pkg::V_TOTAL,
		parameter int V_SYNC_START = video_timing_pkg::V_SYNC_START,
		parameter int V_SYNC_LEN   = video_timing_pkg::V_SYNC_LEN
	)
	(
		input  logic      clk_6m,
		input  logic      arst_n,
		input  cpu_addr_t cpu_addr,
		input  cpu_data_t cpu_data,
		input  logic      cpu_we,
		output dot_t      dot,
		output logic      blank_n,
		output logic      hsync_n,
		output logic      vsync_n
	);

	// raster position shared by all blocks
	beam_if beam ();

	// layer 0 feeds mixer input a, layer 1 feeds input b
	pixel_t    l0_pixel;
	bank_t     l0_bank;
	priority_t l0_priority;
	pixel_t    l1_pixel;
	bank_t     l1_bank;
	priority_t l1_priority;

	////////////////////////////////////////
	// beam counter
	////////////////////////////////////////

	beam_counter #(
		.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
		.H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
		.V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
	) u_beam (
		.clk_6m(clk_6m), .arst_n(arst_n), .beam(beam)
	);

	////////////////////////////////////////
	// tile layers
	////////////////////////////////////////

	tile_layer #(.LAYER_ID(0)) u_layer0 (
		.clk_6m(clk_6m), .arst_n(arst_n), .beam(beam),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.layer_pixel(l0_pixel), .layer_bank(l0_bank), .layer_priority(l0_priority)
	);

	tile_layer #(.LAYER_ID(1)) u_layer1 (
		.clk_6m(clk_6m), .arst_n(arst_n), .beam(beam),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.layer_pixel(l1_pixel), .layer_bank(l1_bank), .layer_priority(l1_priority)
	);

	// priority mix and palette
	layer_mixer u_mixer (
		.clk_6m(clk_6m), .arst_n(arst_n), .beam(beam),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.a_pixel(l0_pixel), .a_bank(l0_bank), .a_priority(l0_priority),
		.b_pixel(l1_pixel), .b_bank(l1_bank), .b_priority(l1_priority),
		.dot(dot), .blank_n(blank_n), .hsync_n(hsync_n), .vsync_n(vsync_n)
	);

endmodule

// ==== dv/tilegen_tb.sv ====
`timescale 1ns/1ps

module tilegen_tb
	import video_timing_pkg::*;
	import tile_pkg::*;
	();

	// one row per scenario, applied in order
	typedef struct packed {
		scroll_t      scroll_x0;
		scroll_t      scroll_y0;
		scroll_t      scroll_x1;
		scroll_t      scroll_y1;
		priority_t    prio0;
		priority_t    prio1;
		color_index_t background;
		logic         clear_b;
	} row_t;

	localparam int NUM_ROWS = 6;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

	logic      clk_6m = 1'b0;
	logic      arst_n;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_data;
	logic      cpu_we;
	dot_t      dot;
	logic      blank_n;
	logic      hsync_n;
	logic      vsync_n;

	integer seed;
	row_t   rows [NUM_ROWS];

	// copies of everything written over the bus
	cpu_data_t map_mirror [2][256];
	cpu_data_t pattern_mirror [2][2048];
	dot_t      palette_mirror [128];
	int        scroll_x_m [2];
	int        scroll_y_m [2];
	int        prio_m [2];
	int        background_m;

	tilegen_top UUT (
		.clk_6m(clk_6m), .arst_n(arst_n),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data), .cpu_we(cpu_we),
		.dot(dot), .blank_n(blank_n), .hsync_n(hsync_n), .vsync_n(vsync_n)
	);

	// 8 ns dot clock
	always #4 clk_6m = ~clk_6m;

	////////////////////////////////////////
	// error handling and compares
	////////////////////////////////////////

	task automatic abort_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_dot(string name, dot_t got, dot_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%02h expected=%02h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_blank(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, exp);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// bus writes, each mirrored
	////////////////////////////////////////

	task automatic write_bus(int addr, int data);
		@(negedge clk_6m);
		cpu_addr = cpu_addr_t'(addr);
		cpu_data = cpu_data_t'(data);
		cpu_we   = 1'b1;
	endtask

	task automatic bus_idle();
		@(negedge clk_6m);
		cpu_we = 1'b0;
	endtask

	task automatic fill_memories();
		cpu_data_t value;
		for (int layer = 0; layer < 2; layer++) begin
			for (int i = 0; i < 256; i++) begin
				value = $random(seed);
				map_mirror[layer][i] = value;
				write_bus(MAP_BASE + layer * MAP_STRIDE + i, value);
			end
			for (int i = 0; i < 2048; i++) begin
				value = $random(seed);
				pattern_mirror[layer][i] = value;
				write_bus(PATTERN_BASE + layer * PATTERN_STRIDE + i, value);
			end
		end
		for (int i = 0; i < PALETTE_SIZE; i++) begin
			value = $random(seed);
			palette_mirror[i] = value;
			write_bus(PALETTE_BASE + i, value);
		end
		bus_idle();
	endtask

	// all pens of a layer go transparent
	task automatic clear_patterns(int layer);
		for (int i = 0; i < 2048; i++) begin
			pattern_mirror[layer][i] = '0;
			write_bus(PATTERN_BASE + layer * PATTERN_STRIDE + i, 0);
		end
	endtask

	task automatic apply_row(row_t r);
		if (r.clear_b) clear_patterns(1);
		scroll_x_m = '{int'(r.scroll_x0), int'(r.scroll_x1)};
		scroll_y_m = '{int'(r.scroll_y0), int'(r.scroll_y1)};
		prio_m = '{int'(r.prio0), int'(r.prio1)};
		background_m = r.background;
		for (int layer = 0; layer < 2; layer++) begin
			write_bus(REG_BASE + layer * REG_STRIDE + REG_SCROLL_X, scroll_x_m[layer]);
			write_bus(REG_BASE + layer * REG_STRIDE + REG_SCROLL_Y, scroll_y_m[layer]);
			write_bus(REG_BASE + layer * REG_STRIDE + REG_PRIORITY, prio_m[layer]);
		end
		write_bus(BACKGROUND_REG, background_m);
		bus_idle();
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// bank times 8 plus pixel for one layer at one raster spot
	function automatic int layer_lookup(int layer, int x, int y);
		int mx;
		int my;
		int entry;
		int pix;
		mx    = (x + scroll_x_m[layer]) % 128;
		my    = (y + scroll_y_m[layer]) % 128;
		entry = map_mirror[layer][(my / 8) * 16 + mx / 8];
		// code in the low 5 bits, pixel in the low 3 bits of the pattern byte
		pix   = pattern_mirror[layer][(entry % 32) * 64 + (my % 8) * 8 + mx % 8] % 8;
		return (entry / 32) * 8 + pix;
	endfunction

	function automatic dot_t expected_dot(int x, int y);
		int a;
		int b;
		int index;
		if (x >= H_ACTIVE || y >= V_ACTIVE) return '0;
		a = layer_lookup(0, x, y);
		b = layer_lookup(1, x, y);
		// b only on strictly higher priority or a transparent
		if (b % 8 != 0 && (a % 8 == 0 || prio_m[1] > prio_m[0])) begin
			index = 64 + b;
		end else if (a % 8 != 0) begin
			index = a;
		end else begin
			index = background_m;
		end
		return palette_mirror[index];
	endfunction

	task automatic check_position(int x, int y);
		string where;
		where = $sformatf(" at x=%0d y=%0d", x, y);
		check_blank({"blank_n", where}, blank_n, x < H_ACTIVE && y < V_ACTIVE);
		check_blank({"hsync_n", where}, hsync_n,
			!(x >= H_SYNC_START && x < H_SYNC_START + H_SYNC_LEN));
		check_blank({"vsync_n", where}, vsync_n,
			!(y >= V_SYNC_START && y < V_SYNC_START + V_SYNC_LEN));
		check_dot({"dot", where}, dot, expected_dot(x, y));
	endtask

	task automatic check_idle();
		check_blank("blank_n", blank_n, 1'b0);
		check_blank("hsync_n", hsync_n, 1'b1);
		check_blank("vsync_n", vsync_n, 1'b1);
		check_dot("dot", dot, '0);
	endtask

	////////////////////////////////////////
	// frame tracking
	////////////////////////////////////////

	task automatic wait_vsync_fall(int row);
		logic prev;
		int   cycles;
		bit   seen;
		prev   = vsync_n;
		cycles = 0;
		seen   = 1'b0;
		while (!seen) begin
			@(negedge clk_6m);
			seen   = prev && !vsync_n;
			prev   = vsync_n;
			cycles = cycles + 1;
			if (!seen && cycles > 2 * FRAME_CYCLES) begin
				$display("timeout: vsync_n never fell while waiting for frame of row %0d", row);
				abort_run();
			end
		end
	endtask

	// entered on the sample where vsync_n fell, line V_SYNC_START dot 0
	task automatic check_frame();
		int   x;
		int   y;
		logic hsync_prev;
		logic vsync_prev;
		x = 0;
		y = V_SYNC_START;
		hsync_prev = hsync_n;
		vsync_prev = vsync_n;
		check_position(x, y);
		repeat (FRAME_CYCLES - 1) begin
			@(negedge clk_6m);
			x = x + 1;
			if (x == H_TOTAL) begin
				x = 0;
				y = (y + 1) % V_TOTAL;
			end
			// resync own counters on sync edges
			if (hsync_prev && !hsync_n) x = H_SYNC_START;
			if (vsync_prev && !vsync_n) begin
				x = 0;
				y = V_SYNC_START;
			end
			hsync_prev = hsync_n;
			vsync_prev = vsync_n;
			check_position(x, y);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		seed     = 32'h2710_1190;
		arst_n   = 1'b0;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_we   = 1'b0;
		// scroll x0, y0, x1, y1, prio 0, prio 1, background, clear b
		rows[0] = '{7'd0, 7'd0, 7'd0, 7'd0, 3'd0, 3'd0, 7'h05, 1'b0};
		rows[1] = '{7'd3, 7'd0, 7'd0, 7'd5, 3'd2, 3'd5, 7'h11, 1'b0};
		rows[2] = '{7'd127, 7'd126, 7'd1, 7'd125, 3'd6, 3'd1, 7'h22, 1'b0};
		rows[3] = '{7'd64, 7'd100, 7'd120, 7'd7, 3'd4, 3'd4, 7'h33, 1'b0};
		// layer b emptied from here on
		rows[4] = '{7'd9, 7'd33, 7'd77, 7'd127, 3'd7, 3'd0, 7'h7f, 1'b1};
		rows[5] = '{7'd0, 7'd0, 7'd0, 7'd0, 3'd0, 3'd3, 7'h40, 1'b0};

		// reset for 4 cycles, outputs idle throughout
		repeat (3) @(negedge clk_6m);
		check_idle();
		@(negedge clk_6m);
		arst_n = 1'b1;
		// first beam position reaches the outputs after the pipeline
		repeat (PIPE_DEPTH) begin
			@(negedge clk_6m);
			check_idle();
		end
		// dot 0 of line 0 shows up exactly one pipeline after the first beam clock
		@(negedge clk_6m);
		check_blank("blank_n", blank_n, 1'b1);
		check_blank("hsync_n", hsync_n, 1'b1);
		check_blank("vsync_n", vsync_n, 1'b1);

		fill_memories();
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(rows[r]);
			wait_vsync_fall(r);
			check_frame();
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== tilegen.f ====
logic/video_timing_pkg.sv
logic/tile_pkg.sv
logic/beam_if.sv
logic/beam_counter.sv
logic/tile_layer.sv
logic/layer_mixer.sv
logic/tilegen_top.sv
dv/tilegen_tb.sv
